//--- rtl/lsu_pkg.sv
// Load/store bridge package
// Widths, enums and request/response structs shared by the CPU and cache side

package lsu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int XLEN     = 64;   // Data and address width
    localparam int OFFSET_W = 3;    // Byte offset inside a double word
    localparam int BE_W     = 8;    // One enable per byte

    typedef logic [XLEN-1:0]     xlen_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [BE_W-1:0]     be_t;

    // ------------------------------
    // Enums
    // ------------------------------
    // Instruction kinds from the CPU
    typedef enum logic [3:0] {
        NONE,
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU,
        SD,
        SW,
        SH,
        SB
    } mem_instr_e;

    typedef enum logic [1:0] {
        OP_NOP,
        OP_LOAD,
        OP_STORE
    } mem_op_e;

    // log2 of the byte count
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_RESP
    } ctrl_state_e;

    // ------------------------------
    // Structs
    // ------------------------------
    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        logic      sign;    // Sign extend on load
    } op_dec_t;

    typedef struct packed {
        logic       valid;
        logic       kill;
        mem_instr_e instr;
        xlen_t      rs1;
        xlen_t      rs2;    // Store data
        xlen_t      imm;
    } cpu_req_t;

    typedef struct packed {
        logic  ready;
        logic  lock;        // Stalls the CPU
        logic  xcpt_ma_ld;
        logic  xcpt_ma_st;
        xlen_t data;
        xlen_t addr;
    } cpu_resp_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        xlen_t     addr;
        xlen_t     wdata;
        be_t       be;
        mem_size_e size;
    } dc_req_t;

    typedef struct packed {
        logic  gnt;     // Request taken
        logic  valid;   // Load data present
        xlen_t data;
    } dc_resp_t;

endpackage

//--- rtl/mem_op_decoder.sv
// Memory instruction decoder
// Maps the CPU instruction kind to operation class, access size and sign

module mem_op_decoder (
    input  lsu_pkg::mem_instr_e instr_i,
    output lsu_pkg::op_dec_t    dec_o
);

    always_comb begin
        // Default is no memory operation
        dec_o.op   = lsu_pkg::OP_NOP;
        dec_o.size = lsu_pkg::SZ_B;
        dec_o.sign = 1'b0;

        case (instr_i)
            // Signed loads
            lsu_pkg::LD: begin
                dec_o.op   = lsu_pkg::OP_LOAD;
                dec_o.size = lsu_pkg::SZ_D;
                dec_o.sign = 1'b1;
            end
            lsu_pkg::LW: begin
                dec_o.op   = lsu_pkg::OP_LOAD;
                dec_o.size = lsu_pkg::SZ_W;
                dec_o.sign = 1'b1;
            end
            lsu_pkg::LH: begin
                dec_o.op   = lsu_pkg::OP_LOAD;
                dec_o.size = lsu_pkg::SZ_H;
                dec_o.sign = 1'b1;
            end
            lsu_pkg::LB: begin
                dec_o.op   = lsu_pkg::OP_LOAD;
                dec_o.size = lsu_pkg::SZ_B;
                dec_o.sign = 1'b1;
            end
            // Unsigned loads
            lsu_pkg::LWU: begin
                dec_o.op   = lsu_pkg::OP_LOAD;
                dec_o.size = lsu_pkg::SZ_W;
            end
            lsu_pkg::LHU: begin
                dec_o.op   = lsu_pkg::OP_LOAD;
                dec_o.size = lsu_pkg::SZ_H;
            end
            lsu_pkg::LBU: dec_o.op = lsu_pkg::OP_LOAD;   // Byte size by default
            // Stores never extend
            lsu_pkg::SD: begin
                dec_o.op   = lsu_pkg::OP_STORE;
                dec_o.size = lsu_pkg::SZ_D;
            end
            lsu_pkg::SW: begin
                dec_o.op   = lsu_pkg::OP_STORE;
                dec_o.size = lsu_pkg::SZ_W;
            end
            lsu_pkg::SH: begin
                dec_o.op   = lsu_pkg::OP_STORE;
                dec_o.size = lsu_pkg::SZ_H;
            end
            lsu_pkg::SB: dec_o.op = lsu_pkg::OP_STORE;
            default: ;   // NONE stays a NOP
        endcase
    end

endmodule

//--- rtl/dcache_req_ctrl.sv
// Data cache request controller
// Captures one CPU request, checks alignment and holds it toward the cache

module dcache_req_ctrl (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  lsu_pkg::cpu_req_t req_i,
    input  lsu_pkg::op_dec_t  dec_i,
    input  lsu_pkg::dc_resp_t dc_resp_i,
    output lsu_pkg::dc_req_t  dc_req_o,
    output logic              ready_o,
    output logic              lock_o,
    output logic              xcpt_ma_ld_o,
    output logic              xcpt_ma_st_o,
    output lsu_pkg::xlen_t    addr_o,
    output lsu_pkg::op_dec_t  load_dec_o,
    output lsu_pkg::offset_t  offset_o
);

    lsu_pkg::ctrl_state_e state_q, state_d;

    lsu_pkg::xlen_t   eff_addr;
    lsu_pkg::offset_t eff_offset;
    lsu_pkg::offset_t size_mask;   // Low address bits that must be zero
    lsu_pkg::be_t     size_be;     // Enables before shifting to the offset
    logic             misaligned;
    logic             accept;

    // Captured request
    lsu_pkg::op_dec_t dec_q;
    lsu_pkg::xlen_t   addr_q;
    lsu_pkg::xlen_t   wdata_q;
    lsu_pkg::be_t     be_q;
    logic             xcpt_ld_q;
    logic             xcpt_st_q;

    // ------------------------------
    // Address and alignment
    // ------------------------------
    assign eff_addr   = req_i.rs1 + req_i.imm;
    assign eff_offset = eff_addr[lsu_pkg::OFFSET_W-1:0];

    always_comb begin
        case (dec_i.size)
            lsu_pkg::SZ_H: begin
                size_mask = 3'b001;
                size_be   = 8'h03;
            end
            lsu_pkg::SZ_W: begin
                size_mask = 3'b011;
                size_be   = 8'h0f;
            end
            lsu_pkg::SZ_D: begin
                size_mask = 3'b111;
                size_be   = 8'hff;
            end
            default: begin
                size_mask = 3'b000;   // Bytes are always aligned
                size_be   = 8'h01;
            end
        endcase
    end

    assign misaligned = |(eff_offset & size_mask);
    assign accept     = (state_q == lsu_pkg::IDLE) & req_i.valid & ~req_i.kill
                      & (dec_i.op != lsu_pkg::OP_NOP);

    // ------------------------------
    // State machine
    // ------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::IDLE:
                if (accept && !misaligned) state_d = lsu_pkg::REQ;
            lsu_pkg::REQ: begin
                if (req_i.kill) begin
                    state_d = lsu_pkg::IDLE;
                end else if (dc_resp_i.gnt) begin
                    // Store done on gnt, load may get data in the same cycle
                    if (dec_q.op == lsu_pkg::OP_STORE || dc_resp_i.valid) begin
                        state_d = lsu_pkg::IDLE;
                    end else begin
                        state_d = lsu_pkg::WAIT_RESP;
                    end
                end
            end
            lsu_pkg::WAIT_RESP:
                if (req_i.kill || dc_resp_i.valid) state_d = lsu_pkg::IDLE;
            default: state_d = lsu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= lsu_pkg::IDLE;
            xcpt_ld_q <= 1'b0;
            xcpt_st_q <= 1'b0;
            dec_q     <= '0;
            addr_q    <= '0;
        end else begin
            state_q   <= state_d;
            xcpt_ld_q <= accept & misaligned & (dec_i.op == lsu_pkg::OP_LOAD);
            xcpt_st_q <= accept & misaligned & (dec_i.op == lsu_pkg::OP_STORE);
            if (accept) begin
                dec_q  <= dec_i;
                addr_q <= eff_addr;
            end
        end
    end

    // Store payload, placed at the byte offset
    always_ff @(posedge clk_i) begin
        if (accept) begin
            wdata_q <= req_i.rs2 << {eff_offset, 3'b000};
            be_q    <= size_be << eff_offset;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign dc_req_o.valid = (state_q == lsu_pkg::REQ);
    assign dc_req_o.we    = (dec_q.op == lsu_pkg::OP_STORE);
    assign dc_req_o.addr  = addr_q;
    assign dc_req_o.wdata = wdata_q;
    assign dc_req_o.be    = be_q;
    assign dc_req_o.size  = dec_q.size;

    // Completion, never on a killed request
    assign ready_o = ~req_i.kill & (
          ((state_q == lsu_pkg::REQ) & dc_resp_i.gnt
              & ((dec_q.op == lsu_pkg::OP_STORE) | dc_resp_i.valid))
        | ((state_q == lsu_pkg::WAIT_RESP) & dc_resp_i.valid));

    assign lock_o       = (state_q != lsu_pkg::IDLE) & ~ready_o;
    assign xcpt_ma_ld_o = xcpt_ld_q;
    assign xcpt_ma_st_o = xcpt_st_q;
    assign addr_o       = addr_q;
    assign load_dec_o   = dec_q;
    assign offset_o     = addr_q[lsu_pkg::OFFSET_W-1:0];

endmodule

//--- rtl/load_align.sv
// Load data aligner
// Moves the addressed bytes down and zero or sign extends them

module load_align (
    input  lsu_pkg::xlen_t   data_i,
    input  lsu_pkg::op_dec_t dec_i,
    input  lsu_pkg::offset_t offset_i,
    output lsu_pkg::xlen_t   data_o
);

    lsu_pkg::xlen_t shifted;
    logic           fill;   // Value of the upper bits

    assign shifted = data_i >> {offset_i, 3'b000};

    always_comb begin
        case (dec_i.size)
            lsu_pkg::SZ_B: begin
                fill   = dec_i.sign & shifted[7];
                data_o = {{(lsu_pkg::XLEN-8){fill}}, shifted[7:0]};
            end
            lsu_pkg::SZ_H: begin
                fill   = dec_i.sign & shifted[15];
                data_o = {{(lsu_pkg::XLEN-16){fill}}, shifted[15:0]};
            end
            lsu_pkg::SZ_W: begin
                fill   = dec_i.sign & shifted[31];
                data_o = {{(lsu_pkg::XLEN-32){fill}}, shifted[31:0]};
            end
            default: begin
                fill   = 1'b0;      // Full word, nothing to extend
                data_o = shifted;
            end
        endcase
    end

endmodule

//--- rtl/lsu_dcache_if.sv
// Load/store bridge top
// Decoder, request controller and load aligner between CPU and data cache

module lsu_dcache_if (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  lsu_pkg::cpu_req_t  cpu_req_i,
    output lsu_pkg::cpu_resp_t cpu_resp_o,
    output lsu_pkg::dc_req_t   dc_req_o,
    input  lsu_pkg::dc_resp_t  dc_resp_i
);

    lsu_pkg::op_dec_t dec;
    lsu_pkg::op_dec_t load_dec;   // Operation of the open request
    lsu_pkg::offset_t offset;

    mem_op_decoder i_mem_op_decoder (
        .instr_i (cpu_req_i.instr),
        .dec_o   (dec)
    );

    dcache_req_ctrl i_dcache_req_ctrl (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_i        (cpu_req_i),
        .dec_i        (dec),
        .dc_resp_i    (dc_resp_i),
        .dc_req_o     (dc_req_o),
        .ready_o      (cpu_resp_o.ready),
        .lock_o       (cpu_resp_o.lock),
        .xcpt_ma_ld_o (cpu_resp_o.xcpt_ma_ld),
        .xcpt_ma_st_o (cpu_resp_o.xcpt_ma_st),
        .addr_o       (cpu_resp_o.addr),
        .load_dec_o   (load_dec),
        .offset_o     (offset)
    );

    load_align i_load_align (
        .data_i   (dc_resp_i.data),
        .dec_i    (load_dec),
        .offset_i (offset),
        .data_o   (cpu_resp_o.data)
    );

endmodule

//--- bench/lsu_dcache_if_assertions.sv
// Load/store bridge checker
// Shadows the open request from the CPU side and checks both bus sides

module lsu_dcache_if_assertions (
    input logic               clk_i,
    input logic               rstn_i,
    input lsu_pkg::cpu_req_t  cpu_req_i,
    input lsu_pkg::cpu_resp_t cpu_resp_o,
    input lsu_pkg::dc_req_t   dc_req_o,
    input lsu_pkg::dc_resp_t  dc_resp_i
);

    int fail_cnt = 0;   // Read by the testbench

    // Shadow of the accepted request
    logic           open_q, granted_q, mis_ld_q, mis_st_q;
    logic           sh_store, sh_sign;
    int             sh_nb, sh_off;
    lsu_pkg::xlen_t sh_addr, sh_wdata, sh_wmask;
    lsu_pkg::be_t   sh_be;

    lsu_pkg::xlen_t ea;
    int             nb;
    logic           acc, mis, done, st;

    function automatic int kind_bytes(lsu_pkg::mem_instr_e k);
        case (k)
            lsu_pkg::LD, lsu_pkg::SD:                 return 8;
            lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW:   return 4;
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH:   return 2;
            default:                                  return 1;
        endcase
    endfunction

    // Bytes of d moved up to the offset, zero elsewhere
    function automatic lsu_pkg::xlen_t place_bytes(lsu_pkg::xlen_t d, int off, int n);
        lsu_pkg::xlen_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            if (off + i < lsu_pkg::BE_W) r[8 * (off + i) +: 8] = d[8 * i +: 8];
        end
        return r;
    endfunction

    function automatic lsu_pkg::be_t byte_mask(int off, int n);
        lsu_pkg::be_t m;
        m = '0;
        for (int i = 0; i < n; i++) begin
            if (off + i < lsu_pkg::BE_W) m[off + i] = 1'b1;
        end
        return m;
    endfunction

    function automatic lsu_pkg::xlen_t extend(lsu_pkg::xlen_t w, int off, int n, logic sgn);
        lsu_pkg::xlen_t r;
        r = w >> (8 * off);
        for (int i = 8 * n; i < lsu_pkg::XLEN; i++) begin
            r[i] = sgn & r[8 * n - 1];   // Top kept bit stays untouched
        end
        return r;
    endfunction

    assign ea   = cpu_req_i.rs1 + cpu_req_i.imm;
    assign nb   = kind_bytes(cpu_req_i.instr);
    assign st   = cpu_req_i.instr inside {lsu_pkg::SD, lsu_pkg::SW, lsu_pkg::SH, lsu_pkg::SB};
    assign mis  = (int'(ea[2:0]) % nb) != 0;
    assign acc  = !open_q && cpu_req_i.valid && !cpu_req_i.kill
                  && (cpu_req_i.instr != lsu_pkg::NONE);
    assign done = open_q && !cpu_req_i.kill
                  && ((!granted_q && dc_resp_i.gnt && (sh_store || dc_resp_i.valid))
                      || (granted_q && dc_resp_i.valid));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            open_q    <= 1'b0;
            granted_q <= 1'b0;
            mis_ld_q  <= 1'b0;
            mis_st_q  <= 1'b0;
            sh_store  <= 1'b0;
            sh_addr   <= '0;
        end else begin
            mis_ld_q <= acc && mis && !st;
            mis_st_q <= acc && mis && st;
            if (acc) begin
                open_q    <= !mis;
                granted_q <= 1'b0;
                sh_addr   <= ea;
                sh_off    <= int'(ea[2:0]);
                sh_nb     <= nb;
                sh_store  <= st;
                sh_sign   <= cpu_req_i.instr inside {lsu_pkg::LD, lsu_pkg::LW,
                                                     lsu_pkg::LH, lsu_pkg::LB};
                sh_be     <= byte_mask(int'(ea[2:0]), nb);
                sh_wdata  <= place_bytes(cpu_req_i.rs2, int'(ea[2:0]), nb);
                sh_wmask  <= place_bytes('1, int'(ea[2:0]), nb);
            end else if (open_q) begin
                if (cpu_req_i.kill || done) open_q <= 1'b0;
                else if (dc_resp_i.gnt) granted_q <= 1'b1;   // Load waits for data
            end
        end
    end

    // ------------------------------
    // Cache side
    // ------------------------------
    a_req_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dc_req_o.valid == (open_q && !granted_q))
        else begin
            $error("Error at %0t: cache request valid wrong", $time);
            fail_cnt++;
        end

    a_req_payload: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dc_req_o.valid |-> dc_req_o.addr == sh_addr && dc_req_o.we == sh_store
            && (1 << dc_req_o.size) == sh_nb
            && (!sh_store || (dc_req_o.be == sh_be
                              && (dc_req_o.wdata & sh_wmask) == sh_wdata)))
        else begin
            $error("Error at %0t: cache request payload wrong", $time);
            fail_cnt++;
        end

    a_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dc_req_o.valid && !dc_resp_i.gnt && !cpu_req_i.kill |=> $stable(dc_req_o))
        else begin
            $error("Error at %0t: cache request changed before gnt", $time);
            fail_cnt++;
        end

    // ------------------------------
    // CPU side
    // ------------------------------
    a_load_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cpu_resp_o.ready && !sh_store
            |-> cpu_resp_o.data == extend(dc_resp_i.data, sh_off, sh_nb, sh_sign))
        else begin
            $error("Error at %0t: load data wrong", $time);
            fail_cnt++;
        end

    a_xcpt: assert property (@(posedge clk_i) disable iff (!rstn_i)
        {cpu_resp_o.xcpt_ma_ld, cpu_resp_o.xcpt_ma_st} == {mis_ld_q, mis_st_q})
        else begin
            $error("Error at %0t: misalign exception wrong", $time);
            fail_cnt++;
        end

    a_kill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        open_q && cpu_req_i.kill |-> !cpu_resp_o.ready)
        else begin
            $error("Error at %0t: ready on a killed request", $time);
            fail_cnt++;
        end

    a_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cpu_resp_o.ready == done)
        else begin
            $error("Error at %0t: ready wrong", $time);
            fail_cnt++;
        end

    a_lock: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cpu_resp_o.lock == (open_q && !done))
        else begin
            $error("Error at %0t: lock wrong", $time);
            fail_cnt++;
        end

    a_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cpu_resp_o.addr == sh_addr)
        else begin
            $error("Error at %0t: response address wrong", $time);
            fail_cnt++;
        end

    a_reset: assert property (@(posedge clk_i)
        !rstn_i |-> !cpu_resp_o.lock && !cpu_resp_o.ready && !dc_req_o.valid
            && !cpu_resp_o.xcpt_ma_ld && !cpu_resp_o.xcpt_ma_st)
        else begin
            $error("Error at %0t: outputs active in reset", $time);
            fail_cnt++;
        end

endmodule

bind lsu_dcache_if lsu_dcache_if_assertions i_lsu_dcache_if_assertions (.*);

//--- bench/tb_lsu_dcache_if.sv
// Load/store bridge testbench
// Cache model with random latency, directed and random CPU requests

module tb_lsu_dcache_if;

    // About 400 operations of at most a dozen cycles each, with wide margin
    localparam int MAX_CYCLES = 20000;

    logic clk  = 1'b0;
    logic rstn = 1'b0;
    int   seed = 32'h4aa9042c;
    int   cycles = 0;
    int   ops = 0;

    lsu_pkg::cpu_req_t  cpu_req = '0;
    lsu_pkg::cpu_resp_t cpu_resp;
    lsu_pkg::dc_req_t   dc_req;
    lsu_pkg::dc_resp_t  dc_resp = '0;

    // Cache model state
    lsu_pkg::xlen_t mem [16];
    logic [3:0]     rd_idx;
    logic           pend;
    int             gnt_wait, resp_wait;

    lsu_dcache_if i_lsu_dcache_if (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .cpu_req_i  (cpu_req),
        .cpu_resp_o (cpu_resp),
        .dc_req_o   (dc_req),
        .dc_resp_i  (dc_resp)
    );

    initial forever #2 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    // ------------------------------
    // Cache model
    // ------------------------------
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dc_resp   <= '0;
            pend      <= 1'b0;
            gnt_wait  <= 0;
            resp_wait <= 0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= {~(32'(i) * 32'h85ebca6b), 32'(i) * 32'h9e3779b9};
            end
        end else begin
            dc_resp.gnt   <= 1'b0;
            dc_resp.valid <= 1'b0;
            if (cpu_req.kill) begin
                pend <= 1'b0;                 // Killed load gets no data
            end else if (pend) begin
                if (resp_wait == 0) begin
                    dc_resp.valid <= 1'b1;
                    dc_resp.data  <= mem[rd_idx];
                    pend          <= 1'b0;
                end else begin
                    resp_wait <= resp_wait - 1;
                end
            end else if (dc_req.valid && !dc_resp.gnt) begin
                if (gnt_wait == 0) begin
                    dc_resp.gnt <= 1'b1;
                    gnt_wait    <= int'($unsigned($random(seed)) % 4);
                    if (dc_req.we) begin
                        for (int i = 0; i < 8; i++) begin
                            if (dc_req.be[i]) begin
                                mem[dc_req.addr[6:3]][8 * i +: 8] <= dc_req.wdata[8 * i +: 8];
                            end
                        end
                    end else begin
                        pend      <= 1'b1;
                        rd_idx    <= dc_req.addr[6:3];
                        resp_wait <= int'($unsigned($random(seed)) % 3);
                    end
                end else begin
                    gnt_wait <= gnt_wait - 1;
                end
            end
        end
    end

    // One CPU request, then wait for its end; kill_at < 0 means no kill
    task automatic run_op(input lsu_pkg::mem_instr_e kind, input lsu_pkg::xlen_t base,
                          input lsu_pkg::xlen_t ofs, input int kill_at);
        int   c;
        logic done;
        c    = 0;
        done = 1'b0;
        while (cpu_resp.lock) @(posedge clk);
        cpu_req.valid <= 1'b1;
        cpu_req.instr <= kind;
        cpu_req.rs1   <= base;
        cpu_req.imm   <= ofs;
        cpu_req.rs2   <= {$random(seed), $random(seed)};
        @(posedge clk);                        // Accepted here
        cpu_req.valid <= 1'b0;
        ops++;
        while (!done) begin
            @(posedge clk);
            if (cpu_resp.ready || cpu_resp.xcpt_ma_ld || cpu_resp.xcpt_ma_st
                || !cpu_resp.lock) begin
                done = 1'b1;
            end else if (c == kill_at) begin
                cpu_req.kill <= 1'b1;
                @(posedge clk);
                cpu_req.kill <= 1'b0;
                done = 1'b1;
            end
            c++;
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin : stimulus
        lsu_pkg::mem_instr_e kind;
        int                  kill_at;
        int                  fails;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        // Every kind at every byte offset
        for (int k = 0; k < 12; k++) begin
            for (int off = 0; off < 8; off++) begin
                run_op(lsu_pkg::mem_instr_e'(4'(k)), 64'h1000 + 64'(k * 64), 64'(off), -1);
            end
        end
        for (int k = 0; k < 3; k++) begin
            run_op(lsu_pkg::LD, 64'h2000, 64'h8, k);
            run_op(lsu_pkg::SW, 64'h2000, 64'h4, k);
        end
        for (int n = 0; n < 300; n++) begin
            kind    = lsu_pkg::mem_instr_e'(4'(1 + $unsigned($random(seed)) % 11));
            kill_at = ($unsigned($random(seed)) % 8 == 0) ? int'($unsigned($random(seed)) % 3)
                                                           : -1;
            run_op(kind, {$random(seed), $random(seed)} & ~64'h7,
                   ($random(seed) & 1) ? 64'($unsigned($random(seed)) % 8) : 64'h0, kill_at);
        end
        repeat (4) @(posedge clk);
        fails = i_lsu_dcache_if.i_lsu_dcache_if_assertions.fail_cnt;
        $display("Done: %0d operations, %0d errors", ops, fails);
        if (fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycles >= MAX_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- all.f
rtl/lsu_pkg.sv
rtl/mem_op_decoder.sv
rtl/dcache_req_ctrl.sv
rtl/load_align.sv
rtl/lsu_dcache_if.sv
bench/lsu_dcache_if_assertions.sv
bench/tb_lsu_dcache_if.sv

//--- Makefile
TOP := tb_lsu_dcache_if

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
